/* design/csum_pkg.sv */
package csum_pkg;

	localparam int WORD_W = 32;   // input word
	localparam int CSUM_W = 16;   // checksum and lane width

	// prefix network structure
	typedef enum logic [1:0] {
		SLOW   = 2'b00,   // serial chain
		MEDIUM = 2'b01,   // brent-kung
		FAST   = 2'b10    // sklansky
	} speed_e;

	localparam speed_e PREFIX_SPEED = FAST;

	// frontend fsm codes
	localparam logic [1:0] ST_IDLE     = 2'd0;
	localparam logic [1:0] ST_ACK      = 2'd1;   // word taken, step out
	localparam logic [1:0] ST_WAIT_REL = 2'd2;   // waiting for in_req to drop

	// one input word, bytes for masking or half-words for the lanes
	typedef union packed {
		logic [WORD_W/8-1:0][7:0] bytes;   // byte 3 first on the wire
		struct packed {
			logic [CSUM_W-1:0] hi;
			logic [CSUM_W-1:0] lo;
		} half;
	} word_u;

endpackage

/* design/prefix_and_or.sv */
`timescale 1ns/1ns

module prefix_and_or #(
	parameter int              width = 16,              // operand width
	parameter csum_pkg::speed_e speed = csum_pkg::FAST  // structure select
) (
	input  logic [width-1:0] gi,   // bit generate
	input  logic [width-1:0] pi,   // bit propagate
	output logic [width-1:0] go,   // group generate, bits j..0
	output logic [width-1:0] po    // group propagate, bits j..0
);

	if (speed == csum_pkg::FAST) begin : g_sklansky
		// log2 levels, fanout doubles per level
		logic [$clog2(width):0][width-1:0] gt, pt;

		assign gt[0] = gi;
		assign pt[0] = pi;

		for (genvar l = 1; l <= $clog2(width); l++) begin : g_lvl
			for (genvar j = 0; j < width; j++) begin : g_bit
				// upper half of each 2^l block takes the last bit of the lower half
				if (((j >> (l - 1)) % 2) == 1) begin : g_black
					assign gt[l][j] = gt[l-1][j]
						| (pt[l-1][j] & gt[l-1][((j >> (l - 1)) << (l - 1)) - 1]);
					assign pt[l][j] = pt[l-1][j]
						& pt[l-1][((j >> (l - 1)) << (l - 1)) - 1];
				end else begin : g_white
					assign gt[l][j] = gt[l-1][j];   // pass through
					assign pt[l][j] = pt[l-1][j];
				end
			end
		end

		assign go = gt[$clog2(width)];
		assign po = pt[$clog2(width)];
	end else if (speed == csum_pkg::MEDIUM) begin : g_brent_kung
		logic [$clog2(width):0][width-1:0] ug, up;   // up-sweep levels
		logic [$clog2(width):1][width-1:0] dg, dp;   // down-sweep, index by span

		assign ug[0] = gi;
		assign up[0] = pi;

		// up-sweep: bit 2^l-1 of each block combines both halves
		for (genvar l = 1; l <= $clog2(width); l++) begin : g_up
			for (genvar j = 0; j < width; j++) begin : g_bit
				if (((j + 1) % (2 ** l)) == 0) begin : g_black
					assign ug[l][j] = ug[l-1][j] | (up[l-1][j] & ug[l-1][j - 2**(l-1)]);
					assign up[l][j] = up[l-1][j] & up[l-1][j - 2**(l-1)];
				end else begin : g_white
					assign ug[l][j] = ug[l-1][j];
					assign up[l][j] = up[l-1][j];
				end
			end
		end

		assign dg[$clog2(width)] = ug[$clog2(width)];
		assign dp[$clog2(width)] = up[$clog2(width)];

		// down-sweep fills the middle of each span from its finished left edge
		for (genvar d = $clog2(width) - 1; d >= 1; d--) begin : g_dn
			for (genvar j = 0; j < width; j++) begin : g_bit
				if (((j + 1) % (2 ** d)) == 2 ** (d - 1) && (j + 1) > 2 ** d) begin : g_black
					assign dg[d][j] = dg[d+1][j] | (dp[d+1][j] & dg[d+1][j - 2**(d-1)]);
					assign dp[d][j] = dp[d+1][j] & dp[d+1][j - 2**(d-1)];
				end else begin : g_white
					assign dg[d][j] = dg[d+1][j];
					assign dp[d][j] = dp[d+1][j];
				end
			end
		end

		assign go = dg[1];
		assign po = dp[1];
	end else begin : g_serial
		// ripple chain, smallest area
		logic [width-1:0] gt, pt;

		assign gt[0] = gi[0];
		assign pt[0] = pi[0];

		for (genvar j = 1; j < width; j++) begin : g_bit
			assign gt[j] = gi[j] | (pi[j] & gt[j-1]);
			assign pt[j] = pi[j] & pt[j-1];
		end

		assign go = gt;
		assign po = pt;
	end

endmodule

/* design/eac_adder.sv */
`timescale 1ns/1ns

module eac_adder #(
	parameter int               width = 16,
	parameter csum_pkg::speed_e speed = csum_pkg::FAST
) (
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	output logic [width-1:0] sum   // ones'-complement sum
);

	logic [width-1:0] g, p;     // bit generate / propagate
	logic [width-1:0] gt, pt;   // group terms, no carry-in
	logic [width-2:0] gc;       // carries with end-around carry folded in
	logic             cout;

	assign g = a & b;
	assign p = a ^ b;

	prefix_and_or #(
		.width(width),
		.speed(speed)
	) prefix0 (
		.gi(g),
		.pi(p),
		.go(gt),
		.po(pt)
	);

	// top group generate, independent of carry-in
	assign cout = gt[width-1];

	// one extra level brings cout back in as carry-in
	assign gc = gt[width-2:0] | (pt[width-2:0] & {(width - 1){cout}});

	// carry into bit 0 is cout itself
	assign sum = p ^ {gc, cout};

endmodule

/* design/lane_sum.sv */
`timescale 1ns/1ns

module lane_sum (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       step,    // add word this cycle
	input  logic                       clear,   // packet folded, restart
	input  logic [csum_pkg::CSUM_W-1:0] word,
	output logic [csum_pkg::CSUM_W-1:0] acc
);

	logic [csum_pkg::CSUM_W-1:0] acc_next;

	// acc + word, end-around carry
	eac_adder #(
		.width(csum_pkg::CSUM_W),
		.speed(csum_pkg::PREFIX_SPEED)
	) add0 (
		.a(acc),
		.b(word),
		.sum(acc_next)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc <= '0;
		end else if (clear) begin
			acc <= '0;   // clear beats step
		end else if (step) begin
			acc <= acc_next;
		end
	end

endmodule

/* design/csum_fold.sv */
`timescale 1ns/1ns

module csum_fold (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       fold_start,
	input  logic [csum_pkg::CSUM_W-1:0] hi_acc,
	input  logic [csum_pkg::CSUM_W-1:0] lo_acc,
	output logic                       clear,       // lanes back to zero
	output logic                       fold_busy,   // output handshake open
	output logic [csum_pkg::CSUM_W-1:0] csum,
	output logic                       out_req,
	input  logic                       out_ack
);

	logic [csum_pkg::CSUM_W-1:0] both;   // lanes combined

	eac_adder #(
		.width(csum_pkg::CSUM_W),
		.speed(csum_pkg::PREFIX_SPEED)
	) add0 (
		.a(hi_acc),
		.b(lo_acc),
		.sum(both)
	);

	// result word, held through the handshake
	always_ff @(posedge clk) begin
		if (fold_start)
			csum <= ~both;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_req   <= 1'b0;
			fold_busy <= 1'b0;
			clear     <= 1'b0;
		end else begin
			clear <= fold_start;   // one pulse, lanes already read
			if (fold_start) begin
				out_req   <= 1'b1;
				fold_busy <= 1'b1;
			end else begin
				if (out_req && out_ack)
					out_req <= 1'b0;   // sink took it
				if (fold_busy && !out_req && !out_ack)
					fold_busy <= 1'b0;   // ack released, phase 4 done
			end
		end
	end

endmodule

/* design/csum_frontend.sv */
`timescale 1ns/1ns

module csum_frontend (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       in_req,
	input  csum_pkg::word_u            in_data,
	input  logic                       in_last,
	input  logic [1:0]                 in_bytes,   // valid bytes of last word, 0 = 4
	output logic                       in_ack,
	input  logic                       fold_busy,
	output logic                       step,
	output logic                       fold_start,
	output logic [csum_pkg::CSUM_W-1:0] hi_word,
	output logic [csum_pkg::CSUM_W-1:0] lo_word
);

	logic [1:0]      state;
	logic            done;      // packet ended, fold not yet released
	logic            last_q;    // accepted word was the last one
	logic            accept;
	csum_pkg::word_u masked;
	csum_pkg::word_u word_q;

	// drop trailing bytes of a short last word
	always_comb begin
		masked = in_data;
		for (int b = 0; b < csum_pkg::WORD_W / 8; b++) begin
			if (in_last && in_bytes != 2'd0 && (b + int'(in_bytes)) < csum_pkg::WORD_W / 8)
				masked.bytes[b] = 8'h00;   // byte beyond the count
		end
	end

	// new word only when idle and the previous packet has left the fold stage
	assign accept = (state == csum_pkg::ST_IDLE) && in_req && !done;

	always_ff @(posedge clk) begin
		if (accept) begin
			word_q <= masked;
			last_q <= in_last;
		end
	end

	assign hi_word = word_q.half.hi;
	assign lo_word = word_q.half.lo;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= csum_pkg::ST_IDLE;
			in_ack     <= 1'b0;
			step       <= 1'b0;
			fold_start <= 1'b0;
			done       <= 1'b0;
		end else begin
			step       <= 1'b0;
			fold_start <= 1'b0;
			// fold_start still high means fold_busy not up yet
			if (done && !fold_busy && !fold_start)
				done <= 1'b0;
			case (state)
				csum_pkg::ST_IDLE: begin
					if (accept) begin
						step   <= 1'b1;
						in_ack <= 1'b1;
						state  <= csum_pkg::ST_ACK;
					end
				end
				csum_pkg::ST_ACK: begin
					fold_start <= last_q;   // lanes settle this cycle
					if (last_q)
						done <= 1'b1;
					if (!in_req) begin
						in_ack <= 1'b0;   // source already let go
						state  <= csum_pkg::ST_IDLE;
					end else begin
						state <= csum_pkg::ST_WAIT_REL;
					end
				end
				csum_pkg::ST_WAIT_REL: begin
					if (!in_req) begin
						in_ack <= 1'b0;
						state  <= csum_pkg::ST_IDLE;
					end
				end
				default: state <= csum_pkg::ST_IDLE;
			endcase
		end
	end

endmodule

/* design/csum_top.sv */
`timescale 1ns/1ns

module csum_top (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       in_req,
	input  csum_pkg::word_u            in_data,
	input  logic                       in_last,
	input  logic [1:0]                 in_bytes,
	output logic                       in_ack,
	output logic [csum_pkg::CSUM_W-1:0] csum,
	output logic                       out_req,
	input  logic                       out_ack
);

	logic                        step, fold_start, clear, fold_busy;
	logic [csum_pkg::CSUM_W-1:0] hi_word, lo_word;   // masked half-words
	logic [csum_pkg::CSUM_W-1:0] hi_acc, lo_acc;     // lane sums

	csum_frontend u_frontend (
		.clk(clk), .rst_n(rst_n),
		.in_req(in_req), .in_data(in_data), .in_last(in_last),
		.in_bytes(in_bytes), .in_ack(in_ack),
		.fold_busy(fold_busy), .step(step), .fold_start(fold_start),
		.hi_word(hi_word), .lo_word(lo_word)
	);

	lane_sum lane_hi (
		.clk(clk), .rst_n(rst_n), .step(step), .clear(clear),
		.word(hi_word), .acc(hi_acc)
	);

	lane_sum lane_lo (
		.clk(clk), .rst_n(rst_n), .step(step), .clear(clear),
		.word(lo_word), .acc(lo_acc)
	);

	csum_fold u_fold (
		.clk(clk), .rst_n(rst_n), .fold_start(fold_start),
		.hi_acc(hi_acc), .lo_acc(lo_acc), .clear(clear),
		.fold_busy(fold_busy), .csum(csum),
		.out_req(out_req), .out_ack(out_ack)
	);

endmodule

/* test/csum_checker.sv */
`timescale 1ns/1ns

module csum_checker (
	input logic clk,
	input logic rst_n,
	input logic in_req,
	input logic in_ack,
	input logic step,
	input logic fold_start,
	input logic last_q,     // frontend's last-word flag
	input logic out_req,
	input logic out_ack
);

	// ack drops only once the source has let go
	a_ack_release: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(in_ack) |-> !$past(in_req))
		else $error("in_ack fell while in_req was still high");

	a_step_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		step |=> !step)
		else $error("step lasted longer than one cycle");

	// last word goes straight to the fold stage
	a_fold_after_last: assert property (@(posedge clk) disable iff (!rst_n)
		step && last_q |=> fold_start)
		else $error("fold_start missing one cycle after a last-word step");

	a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_req && !out_ack |=> out_req)
		else $error("out_req dropped before out_ack");

endmodule

// top-level handshakes plus the frontend's last flag
bind csum_top csum_checker chk0 (
	.clk(clk), .rst_n(rst_n), .in_req(in_req), .in_ack(in_ack),
	.step(step), .fold_start(fold_start), .last_q(u_frontend.last_q),
	.out_req(out_req), .out_ack(out_ack)
);

/* test/csum_monitor.sv */
`timescale 1ns/1ns

module csum_monitor (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        in_ack,
	input  logic [csum_pkg::CSUM_W-1:0] csum,
	input  logic                        out_req,
	input  logic                        out_ack,
	output int                          checks,
	output int                          errors
);

	logic [csum_pkg::WORD_W-1:0] cur_words[$];   // packet still being sent
	logic [csum_pkg::CSUM_W-1:0] exp_q[$];       // expected results, oldest first
	logic [csum_pkg::CSUM_W-1:0] exp_val;
	logic rst_q, req_q, ack_q;
	logic open;   // output handshake not yet closed
	int n_checks = 0;
	int n_errors = 0;

	assign checks = n_checks;
	assign errors = n_errors;

	// 16-bit add, carry wrapped back into bit 0
	function automatic logic [15:0] ones_add(input logic [15:0] a, input logic [15:0] b);
		logic [16:0] s;
		s = {1'b0, a} + {1'b0, b};
		s = {1'b0, s[15:0]} + {16'd0, s[16]};
		return s[15:0];
	endfunction

	function automatic logic [15:0] ref_csum(input logic [1:0] last_bytes);
		logic [15:0] hi, lo;
		logic [31:0] keep;
		csum_pkg::word_u w;
		hi = '0;
		lo = '0;
		foreach (cur_words[i]) begin
			keep = 32'hFFFF_FFFF;
			if (i == cur_words.size() - 1) begin
				case (last_bytes)   // byte 3 is first on the wire
					2'd1: keep = 32'hFF00_0000;
					2'd2: keep = 32'hFFFF_0000;
					2'd3: keep = 32'hFFFF_FF00;
					default: keep = 32'hFFFF_FFFF;
				endcase
			end
			w = cur_words[i] & keep;
			hi = ones_add(hi, w.half.hi);
			lo = ones_add(lo, w.half.lo);
		end
		return ~ones_add(hi, lo);
	endfunction

	// called by the testbench for every word it drives
	task automatic add_word(input logic [31:0] data, input logic last, input logic [1:0] nbytes);
		cur_words.push_back(data);
		if (last) begin
			exp_q.push_back(ref_csum(nbytes));
			cur_words.delete();
		end
	endtask

	always @(posedge clk) begin
		rst_q <= rst_n;
		if (!rst_n) begin
			cur_words.delete();   // unfinished packet is lost
			exp_q.delete();
			req_q <= 1'b0;
			ack_q <= 1'b0;
			open  <= 1'b0;
		end else begin
			req_q <= out_req;
			ack_q <= in_ack;
			if (!rst_q && (in_ack !== 1'b0 || out_req !== 1'b0)) begin
				$display("** Error at %0t: in_ack/out_req expected 0/0 after reset, got %b/%b",
					$time, in_ack, out_req);
				n_errors++;
			end
			if (out_req && !req_q) begin
				open <= 1'b1;
				if (exp_q.size() == 0) begin
					$display("checksum came out at %0t with no packet pending", $time);
					n_errors++;
				end else begin
					exp_val = exp_q.pop_front();
					n_checks++;
					if (csum !== exp_val) begin
						$display("** Error at %0t: csum expected %h, got %h", $time, exp_val, csum);
						n_errors++;
					end
				end
			end
			if (open && !out_req && !out_ack)
				open <= 1'b0;   // sink released ack
			// next packet must wait for the sink
			if (in_ack && !ack_q && (open || out_req)) begin
				$display("** Error at %0t: in_ack expected 0 while output open, got 1", $time);
				n_errors++;
			end
		end
	end

endmodule

/* test/csum_tb.sv */
`timescale 1ns/1ns

module csum_tb;

	logic clk, rst_n;
	logic in_req, in_last, in_ack;
	logic [1:0] in_bytes;
	csum_pkg::word_u in_data;
	logic [csum_pkg::CSUM_W-1:0] csum;
	logic out_req, out_ack;
	int pkts_sent;
	int mon_checks, mon_errors;

	csum_top dut0 (
		.clk(clk), .rst_n(rst_n), .in_req(in_req), .in_data(in_data), .in_last(in_last),
		.in_bytes(in_bytes), .in_ack(in_ack), .csum(csum), .out_req(out_req), .out_ack(out_ack)
	);

	csum_monitor mon0 (
		.clk(clk), .rst_n(dut0.rst_n), .in_ack(dut0.in_ack), .csum(dut0.csum),
		.out_req(dut0.out_req), .out_ack(dut0.out_ack), .checks(mon_checks), .errors(mon_errors)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;   // 4 ns period
	end

	task automatic give_up(input string what);
		$display("timeout at %0t: %s", $time, what);
		$display("*** FAILED ***");
		$finish;
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (in_ack !== level) begin
			@(negedge clk);
			n++;
			if (n > 200)   // covers the longest sink delay
				give_up(level ? "in_ack never rose" : "in_ack never fell");
		end
	endtask

	task automatic send_word(input logic [31:0] data, input logic last, input logic [1:0] nbytes);
		mon0.add_word(data, last, nbytes);
		in_data  = data;
		in_last  = last;
		in_bytes = nbytes;
		in_req   = 1'b1;
		wait_ack(1'b1);
		in_req = 1'b0;
		wait_ack(1'b0);
		if (last)
			pkts_sent++;
	endtask

	task automatic send_random_packet();
		int len;
		logic [1:0] nb;
		len = $urandom_range(1, 8);
		nb  = 2'($urandom_range(0, 3));   // 0 means all four
		for (int i = 0; i < len; i++)
			send_word($urandom(), i == len - 1, nb);
	endtask

	// output sink, random back-pressure
	task automatic drain_output();
		int n;
		int delay;
		forever begin
			n = 0;
			while (out_req !== 1'b1) begin
				@(negedge clk);
				n++;
				if (n > 2000)
					give_up("no checksum came out of the DUT");
			end
			delay = $urandom_range(0, 15);
			repeat (delay) @(negedge clk);
			out_ack = 1'b1;
			n = 0;
			while (out_req !== 1'b0) begin
				@(negedge clk);
				n++;
				if (n > 50)
					give_up("out_req stayed high after out_ack");
			end
			out_ack = 1'b0;
		end
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (mon_checks != pkts_sent || out_req !== 1'b0 || out_ack !== 1'b0) begin
			@(negedge clk);
			n++;
			if (n > 500)
				give_up("DUT did not return every checksum");
		end
	endtask

	initial begin
		void'($urandom(56));
		rst_n     = 1'b0;
		in_req    = 1'b0;
		in_data   = '0;
		in_last   = 1'b0;
		in_bytes  = 2'd0;
		out_ack   = 1'b0;
		pkts_sent = 0;
		fork
			drain_output();
		join_none
		apply_reset();
		send_word(32'hDEAD_BEEF, 1'b1, 2'd0);   // single full word
		send_word(32'hFFFF_FFFF, 1'b0, 2'd0);   // all ones, both lanes wrap
		send_word(32'hFFFF_FFFF, 1'b1, 2'd0);
		send_word(32'h1234_0F0F, 1'b0, 2'd0);   // lanes land on 0xffff
		send_word(32'hEDCB_F0F0, 1'b1, 2'd0);
		send_word(32'hFFFF_8000, 1'b0, 2'd0);   // carry out of both lanes
		send_word(32'h0001_8000, 1'b1, 2'd0);
		for (int p = 0; p < 24; p++)
			send_random_packet();
		wait_drained();
		// half a packet, then reset must drop it
		send_word($urandom(), 1'b0, 2'd0);
		send_word($urandom(), 1'b0, 2'd0);
		apply_reset();
		send_word(32'h0102_0304, 1'b1, 2'd2);
		wait_drained();
		$display("packets %0d, checks %0d, errors %0d", pkts_sent, mon_checks, mon_errors);
		if (mon_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* verilog.f */
design/csum_pkg.sv
design/prefix_and_or.sv
design/eac_adder.sv
design/lane_sum.sv
design/csum_fold.sv
design/csum_frontend.sv
design/csum_top.sv
test/csum_checker.sv
test/csum_monitor.sv
test/csum_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the checksum testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module csum_tb -Mdir obj_dir -o csum_sim -f verilog.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/csum_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1
